// ==== logic/sfp_frame_pkg.sv ====
package sfp_frame_pkg;

	localparam int FRAME_W = 64;
	localparam int WORD_W = 32;
	localparam int ID_W = 2;
	localparam logic [ID_W-1:0] MASTER_ID = 2'd0;

	// header bits 61..36 of every telemetry frame.
	localparam int MARK_W = 26;
	localparam logic [MARK_W-1:0] TELEM_MARK = 26'h200_0000;

	localparam int TELEM_IDX_W = 4;
	localparam int TELEM_COUNT = 9;

	localparam logic [TELEM_IDX_W-1:0] IDX_STATUS = 4'd0;
	localparam logic [TELEM_IDX_W-1:0] IDX_INTL = 4'd1;
	localparam logic [TELEM_IDX_W-1:0] IDX_CURR = 4'd2;
	localparam logic [TELEM_IDX_W-1:0] IDX_VOLT = 4'd3;
	localparam logic [TELEM_IDX_W-1:0] IDX_DC_CURR = 4'd4;
	localparam logic [TELEM_IDX_W-1:0] IDX_DC_VOLT = 4'd5;
	localparam logic [TELEM_IDX_W-1:0] IDX_PHASE_R = 4'd6;
	localparam logic [TELEM_IDX_W-1:0] IDX_PHASE_S = 4'd7;
	localparam logic [TELEM_IDX_W-1:0] IDX_PHASE_T = 4'd8;

	// field positions inside a telemetry frame.
	localparam int ID_MSB = 63;
	localparam int ID_LSB = 62;
	localparam int MARK_MSB = 61;
	localparam int MARK_LSB = 36;
	localparam int IDX_MSB = 35;
	localparam int IDX_LSB = 32;

endpackage

// ==== logic/sfp_reg_pkg.sv ====
package sfp_reg_pkg;

	localparam int ADDR_W = 8;

	localparam logic [ADDR_W-1:0] REG_CTRL = 8'h00;
	localparam logic [ADDR_W-1:0] REG_CMD = 8'h04;
	localparam logic [ADDR_W-1:0] REG_DATA = 8'h08;
	localparam logic [ADDR_W-1:0] REG_RSP_HI = 8'h0C;
	localparam logic [ADDR_W-1:0] REG_RSP_LO = 8'h10;
	localparam logic [ADDR_W-1:0] REG_RX_HI = 8'h14;
	localparam logic [ADDR_W-1:0] REG_RX_LO = 8'h18;
	localparam logic [ADDR_W-1:0] REG_SCMD = 8'h1C;
	localparam logic [ADDR_W-1:0] REG_SDATA = 8'h20;
	localparam logic [ADDR_W-1:0] REG_STATUS = 8'h24;

	// mirror of sender id n, index k sits at n * TELEM_BASE + k * 4.
	localparam logic [ADDR_W-1:0] TELEM_BASE = 8'h40;

	localparam int CTRL_EN = 0;
	localparam int CTRL_MGO = 1;
	localparam int CTRL_SGO = 2;

	localparam int ST_MASTER = 0;
	localparam int ST_PEND = 1;
	localparam int ST_CHUP = 2;

endpackage

// ==== logic/sfp_frame_fifo.sv ====
`timescale 1ns/1ps

module sfp_frame_fifo #(
	parameter int DEPTH = 16
) (
	input logic i_clk,
	input logic i_rst,
	input logic [sfp_frame_pkg::FRAME_W-1:0] i_push_data,
	input logic i_push_valid,
	output logic o_push_ready,
	output logic [sfp_frame_pkg::FRAME_W-1:0] o_pop_data,
	output logic o_pop_valid,
	input logic i_pop_ready,
	output logic [$clog2(DEPTH+1)-1:0] o_count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [sfp_frame_pkg::FRAME_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic push_fire;
	logic pop_fire;

	assign o_push_ready = (o_count != DEPTH);
	assign o_pop_valid = (o_count != 0);
	assign o_pop_data = mem[rd_ptr]; // head falls through.
	assign push_fire = i_push_valid && o_push_ready;
	assign pop_fire = o_pop_valid && i_pop_ready;

	always_ff @(posedge i_clk)
	begin
		if (push_fire)
			mem[wr_ptr] <= i_push_data;
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_count <= '0;
		end
		else
		begin
			if (push_fire)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_fire)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push_fire && !pop_fire)
				o_count <= o_count + 1'b1;
			else if (pop_fire && !push_fire)
				o_count <= o_count - 1'b1;
		end
	end

	a_count_bound: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_count <= DEPTH);

endmodule

// ==== logic/sfp_handler.sv ====
`timescale 1ns/1ps

module sfp_handler #(
	parameter int TELEM_PERIOD = 4000,
	parameter int FIFO_DEPTH = 16
) (
	input logic i_clk,
	input logic i_rst,
	input logic i_en,
	input logic [sfp_frame_pkg::ID_W-1:0] i_node_id,
	input logic i_channel_up,
	input logic i_m_flag,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_m_cmd,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_m_data,
	input logic i_s_flag,
	input logic [sfp_frame_pkg::FRAME_W-1:0] i_s_rsp,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_status,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_intl,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_curr,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_volt,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_dc_curr,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_dc_volt,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_phase_r,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_phase_s,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_phase_t,
	output logic [sfp_frame_pkg::FRAME_W-1:0] o_tx_data,
	output logic o_tx_valid,
	input logic i_tx_ready,
	input logic [sfp_frame_pkg::FRAME_W-1:0] i_rx_data,
	input logic i_rx_valid,
	output logic o_rx_ready,
	output logic [sfp_frame_pkg::FRAME_W-1:0] o_peer_data,
	output logic o_peer_valid,
	input logic i_peer_ready,
	output logic [sfp_frame_pkg::FRAME_W-1:0] o_local_data,
	output logic o_local_valid,
	input logic i_local_ready,
	input logic [sfp_frame_pkg::FRAME_W-1:0] i_peer_pop_data,
	input logic i_peer_pop_valid,
	output logic o_peer_pop_ready,
	input logic [$clog2(FIFO_DEPTH+1)-1:0] i_peer_count,
	input logic [sfp_frame_pkg::FRAME_W-1:0] i_local_pop_data,
	input logic i_local_pop_valid,
	output logic o_local_pop_ready,
	input logic [$clog2(FIFO_DEPTH+1)-1:0] i_local_count,
	output logic o_master,
	output logic o_mrx_stb,
	output logic [sfp_frame_pkg::FRAME_W-1:0] o_mrx_data,
	output logic o_telem_stb,
	output logic [sfp_frame_pkg::ID_W-1:0] o_telem_id,
	output logic [sfp_frame_pkg::TELEM_IDX_W-1:0] o_telem_idx,
	output logic [sfp_frame_pkg::WORD_W-1:0] o_telem_val,
	output logic o_scmd_stb,
	output logic [sfp_frame_pkg::WORD_W-1:0] o_scmd,
	output logic [sfp_frame_pkg::WORD_W-1:0] o_sdata
);

	localparam logic [1:0] IDLE = 2'd0;
	localparam logic [1:0] RUN = 2'd1;
	localparam logic [1:0] DONE = 2'd2;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_SEND_L = 2'd1;
	localparam logic [1:0] S_PEER = 2'd2;
	localparam logic [1:0] S_SEND_P = 2'd3;

	localparam int PCNT_W = $clog2(TELEM_PERIOD + 1);

	logic [1:0] m_state;
	logic [1:0] p_state;
	logic [1:0] s_state;
	logic [PCNT_W-1:0] t_cnt;
	logic [sfp_frame_pkg::TELEM_IDX_W-1:0] t_idx;
	logic [sfp_frame_pkg::TELEM_IDX_W-1:0] t_sel;
	logic [sfp_frame_pkg::WORD_W-1:0] meas [sfp_frame_pkg::TELEM_COUNT];
	logic slave;
	logic tx_fire;
	logic m_load;
	logic local_take;
	logic peer_take;
	logic p_load;
	logic peer_fire;
	logic t_start;
	logic t_last;
	logic t_load;
	logic local_fire;
	logic rx_fire;
	logic rx_telem;

	assign o_master = i_en && (i_node_id == sfp_frame_pkg::MASTER_ID);
	assign slave = i_en && (i_node_id != sfp_frame_pkg::MASTER_ID);

	assign meas[sfp_frame_pkg::IDX_STATUS] = i_status;
	assign meas[sfp_frame_pkg::IDX_INTL] = i_intl;
	assign meas[sfp_frame_pkg::IDX_CURR] = i_curr;
	assign meas[sfp_frame_pkg::IDX_VOLT] = i_volt;
	assign meas[sfp_frame_pkg::IDX_DC_CURR] = i_dc_curr;
	assign meas[sfp_frame_pkg::IDX_DC_VOLT] = i_dc_volt;
	assign meas[sfp_frame_pkg::IDX_PHASE_R] = i_phase_r;
	assign meas[sfp_frame_pkg::IDX_PHASE_S] = i_phase_s;
	assign meas[sfp_frame_pkg::IDX_PHASE_T] = i_phase_t;

	// link transmit, shared by master send and slave arbiter.
	assign tx_fire = o_tx_valid && i_tx_ready;
	assign m_load = (m_state == RUN) && !o_tx_valid;
	assign o_local_pop_ready = slave && (s_state == S_IDLE) && (i_local_count != 0);
	assign o_peer_pop_ready = slave && (i_peer_count != 0) &&
		((s_state == S_PEER) || ((s_state == S_IDLE) && (i_local_count == 0)));
	assign local_take = o_local_pop_ready && i_local_pop_valid;
	assign peer_take = o_peer_pop_ready && i_peer_pop_valid;

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			m_state <= IDLE;
			s_state <= S_IDLE;
			o_tx_valid <= 1'b0;
		end
		else
		begin
			case (m_state)
				IDLE: m_state <= (o_master && i_m_flag) ? RUN : IDLE;
				RUN: m_state <= tx_fire ? DONE : RUN;
				DONE: m_state <= i_m_flag ? DONE : IDLE; // wait for the host to clear.
				default: m_state <= IDLE;
			endcase
			case (s_state)
				S_IDLE:
				begin
					if (local_take)
						s_state <= S_SEND_L;
					else if (peer_take)
						s_state <= S_SEND_P;
				end
				S_SEND_L: s_state <= tx_fire ? S_PEER : S_SEND_L;
				S_PEER: s_state <= peer_take ? S_SEND_P : S_IDLE;
				S_SEND_P: s_state <= tx_fire ? S_IDLE : S_SEND_P;
				default: s_state <= S_IDLE;
			endcase
			if (tx_fire)
				o_tx_valid <= 1'b0;
			else if (m_load || local_take || peer_take)
				o_tx_valid <= 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (m_load)
			o_tx_data <= {i_m_cmd, i_m_data};
		else if (local_take)
			o_tx_data <= i_local_pop_data;
		else if (peer_take)
			o_tx_data <= i_peer_pop_data;
	end

	// slave response into the peer queue.
	assign peer_fire = o_peer_valid && i_peer_ready;
	assign p_load = (p_state == RUN) && !o_peer_valid;

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			p_state <= IDLE;
			o_peer_valid <= 1'b0;
		end
		else
		begin
			case (p_state)
				IDLE: p_state <= (slave && i_s_flag) ? RUN : IDLE;
				RUN: p_state <= peer_fire ? DONE : RUN;
				DONE: p_state <= i_s_flag ? DONE : IDLE;
				default: p_state <= IDLE;
			endcase
			if (peer_fire)
				o_peer_valid <= 1'b0;
			else if (p_load)
				o_peer_valid <= 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (p_load)
			o_peer_data <= i_s_rsp;
	end

	// telemetry sequencer, nine frames per period.
	assign local_fire = o_local_valid && i_local_ready;
	assign t_start = (t_cnt == PCNT_W'(TELEM_PERIOD - 1)) && slave && i_channel_up &&
		!o_local_valid; // a start during a running sequence is dropped.
	assign t_last = (t_idx == sfp_frame_pkg::IDX_PHASE_T);
	assign t_load = t_start || (local_fire && !t_last);
	assign t_sel = o_local_valid ? t_idx + 1'b1 : sfp_frame_pkg::IDX_STATUS;

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			t_cnt <= '0;
			t_idx <= '0;
			o_local_valid <= 1'b0;
		end
		else
		begin
			t_cnt <= (t_cnt == PCNT_W'(TELEM_PERIOD - 1)) ? '0 : t_cnt + 1'b1;
			if (t_start)
			begin
				t_idx <= sfp_frame_pkg::IDX_STATUS;
				o_local_valid <= 1'b1;
			end
			else if (local_fire)
			begin
				if (t_last)
					o_local_valid <= 1'b0;
				else
					t_idx <= t_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (t_load)
			o_local_data <= {i_node_id, sfp_frame_pkg::TELEM_MARK, t_sel, meas[t_sel]};
	end

	// receive decode.
	assign o_rx_ready = 1'b1;
	assign rx_fire = i_rx_valid && o_rx_ready;
	assign rx_telem =
		(i_rx_data[sfp_frame_pkg::MARK_MSB:sfp_frame_pkg::MARK_LSB] ==
			sfp_frame_pkg::TELEM_MARK) &&
		(i_rx_data[sfp_frame_pkg::ID_MSB:sfp_frame_pkg::ID_LSB] !=
			sfp_frame_pkg::MASTER_ID) &&
		(i_rx_data[sfp_frame_pkg::IDX_MSB:sfp_frame_pkg::IDX_LSB] <=
			sfp_frame_pkg::IDX_PHASE_T);

	assign o_scmd_stb = rx_fire && slave; // pending flag set on the accept edge.
	assign o_scmd = i_rx_data[63:32];
	assign o_sdata = i_rx_data[31:0];

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_telem_stb <= 1'b0;
			o_mrx_stb <= 1'b0;
		end
		else
		begin
			o_telem_stb <= rx_fire && o_master && rx_telem;
			o_mrx_stb <= rx_fire && o_master && !rx_telem;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (rx_fire)
		begin
			o_mrx_data <= i_rx_data;
			o_telem_id <= i_rx_data[sfp_frame_pkg::ID_MSB:sfp_frame_pkg::ID_LSB];
			o_telem_idx <= i_rx_data[sfp_frame_pkg::IDX_MSB:sfp_frame_pkg::IDX_LSB];
			o_telem_val <= i_rx_data[31:0];
		end
	end

	a_tx_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data));

endmodule

// ==== logic/sfp_host_regs.sv ====
`timescale 1ns/1ps

module sfp_host_regs (
	input logic i_clk,
	input logic i_rst,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input logic [sfp_reg_pkg::ADDR_W-1:0] i_wb_adr,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_wb_dat,
	output logic [sfp_frame_pkg::WORD_W-1:0] o_wb_dat,
	output logic o_wb_ack,
	input logic i_master,
	input logic i_channel_up,
	input logic i_mrx_stb,
	input logic [sfp_frame_pkg::FRAME_W-1:0] i_mrx_data,
	input logic i_telem_stb,
	input logic [sfp_frame_pkg::ID_W-1:0] i_telem_id,
	input logic [sfp_frame_pkg::TELEM_IDX_W-1:0] i_telem_idx,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_telem_val,
	input logic i_scmd_stb,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_scmd,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_sdata,
	output logic o_en,
	output logic o_m_flag,
	output logic [sfp_frame_pkg::WORD_W-1:0] o_m_cmd,
	output logic [sfp_frame_pkg::WORD_W-1:0] o_m_data,
	output logic o_s_flag,
	output logic [sfp_frame_pkg::FRAME_W-1:0] o_s_rsp
);

	logic [2:0] ctrl;
	logic [sfp_frame_pkg::WORD_W-1:0] rsp_hi;
	logic [sfp_frame_pkg::WORD_W-1:0] rsp_lo;
	logic [sfp_frame_pkg::FRAME_W-1:0] rx_frame;
	logic [sfp_frame_pkg::WORD_W-1:0] scmd;
	logic [sfp_frame_pkg::WORD_W-1:0] sdata;
	logic pend;
	logic [sfp_frame_pkg::WORD_W-1:0] telem_mem [1:3][sfp_frame_pkg::TELEM_COUNT];
	logic [sfp_frame_pkg::WORD_W-1:0] rd_data;
	logic wb_wr;
	logic wb_rd;
	logic tel_hit;

	assign wb_wr = i_wb_cyc && i_wb_stb && i_wb_we && !o_wb_ack;
	assign wb_rd = i_wb_cyc && i_wb_stb && !i_wb_we && !o_wb_ack;
	assign tel_hit = (i_wb_adr >= sfp_reg_pkg::TELEM_BASE) && (i_wb_adr[1:0] == 2'b00) &&
		(i_wb_adr[5:2] <= sfp_frame_pkg::IDX_PHASE_T); // id lives in adr[7:6].

	assign o_en = ctrl[sfp_reg_pkg::CTRL_EN];
	assign o_m_flag = ctrl[sfp_reg_pkg::CTRL_MGO];
	assign o_s_flag = ctrl[sfp_reg_pkg::CTRL_SGO];
	assign o_s_rsp = {rsp_hi, rsp_lo};

	always_comb
	begin
		rd_data = '0;
		case (i_wb_adr)
			sfp_reg_pkg::REG_CTRL: rd_data[2:0] = ctrl;
			sfp_reg_pkg::REG_CMD: rd_data = o_m_cmd;
			sfp_reg_pkg::REG_DATA: rd_data = o_m_data;
			sfp_reg_pkg::REG_RSP_HI: rd_data = rsp_hi;
			sfp_reg_pkg::REG_RSP_LO: rd_data = rsp_lo;
			sfp_reg_pkg::REG_RX_HI: rd_data = rx_frame[63:32];
			sfp_reg_pkg::REG_RX_LO: rd_data = rx_frame[31:0];
			sfp_reg_pkg::REG_SCMD: rd_data = scmd;
			sfp_reg_pkg::REG_SDATA: rd_data = sdata;
			sfp_reg_pkg::REG_STATUS:
			begin
				rd_data[sfp_reg_pkg::ST_MASTER] = i_master;
				rd_data[sfp_reg_pkg::ST_PEND] = pend;
				rd_data[sfp_reg_pkg::ST_CHUP] = i_channel_up;
			end
			default:
			begin
				if (tel_hit)
					rd_data = telem_mem[i_wb_adr[7:6]][i_wb_adr[5:2]];
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_wb_ack <= 1'b0;
			o_wb_dat <= '0;
			ctrl <= '0;
			o_m_cmd <= '0;
			o_m_data <= '0;
			rsp_hi <= '0;
			rsp_lo <= '0;
			rx_frame <= '0;
			scmd <= '0;
			sdata <= '0;
			pend <= 1'b0;
			for (int id = 1; id <= 3; id++)
				for (int k = 0; k < sfp_frame_pkg::TELEM_COUNT; k++)
					telem_mem[id][k] <= '0;
		end
		else
		begin
			o_wb_ack <= i_wb_cyc && i_wb_stb && !o_wb_ack;
			if (wb_rd)
				o_wb_dat <= rd_data;
			if (wb_wr)
			begin
				case (i_wb_adr)
					sfp_reg_pkg::REG_CTRL: ctrl <= i_wb_dat[2:0];
					sfp_reg_pkg::REG_CMD: o_m_cmd <= i_wb_dat;
					sfp_reg_pkg::REG_DATA: o_m_data <= i_wb_dat;
					sfp_reg_pkg::REG_RSP_HI: rsp_hi <= i_wb_dat;
					sfp_reg_pkg::REG_RSP_LO: rsp_lo <= i_wb_dat;
					default: ;
				endcase
			end
			if (i_mrx_stb)
				rx_frame <= i_mrx_data;
			if (i_telem_stb)
				telem_mem[i_telem_id][i_telem_idx] <= i_telem_val;
			if (i_scmd_stb)
			begin
				scmd <= i_scmd;
				sdata <= i_sdata;
				pend <= 1'b1; // a new command wins over the clearing read.
			end
			else if (wb_rd && (i_wb_adr == sfp_reg_pkg::REG_SCMD))
				pend <= 1'b0;
		end
	end

	a_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_wb_ack |=> !o_wb_ack);

endmodule

// ==== logic/sfp_node_top.sv ====
`timescale 1ns/1ps

module sfp_node_top #(
	parameter int TELEM_PERIOD = 4000,
	parameter int FIFO_DEPTH = 16
) (
	input logic i_clk,
	input logic i_rst,
	input logic [sfp_frame_pkg::ID_W-1:0] i_node_id,
	input logic i_channel_up,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input logic [sfp_reg_pkg::ADDR_W-1:0] i_wb_adr,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_wb_dat,
	output logic [sfp_frame_pkg::WORD_W-1:0] o_wb_dat,
	output logic o_wb_ack,
	output logic [sfp_frame_pkg::FRAME_W-1:0] o_tx_data,
	output logic o_tx_valid,
	input logic i_tx_ready,
	input logic [sfp_frame_pkg::FRAME_W-1:0] i_rx_data,
	input logic i_rx_valid,
	output logic o_rx_ready,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_status,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_intl,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_curr,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_volt,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_dc_curr,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_dc_volt,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_phase_r,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_phase_s,
	input logic [sfp_frame_pkg::WORD_W-1:0] i_phase_t
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic en;
	logic master;
	logic m_flag;
	logic s_flag;
	logic [sfp_frame_pkg::WORD_W-1:0] m_cmd;
	logic [sfp_frame_pkg::WORD_W-1:0] m_data;
	logic [sfp_frame_pkg::FRAME_W-1:0] s_rsp;
	logic mrx_stb;
	logic [sfp_frame_pkg::FRAME_W-1:0] mrx_data;
	logic telem_stb;
	logic [sfp_frame_pkg::ID_W-1:0] telem_id;
	logic [sfp_frame_pkg::TELEM_IDX_W-1:0] telem_idx;
	logic [sfp_frame_pkg::WORD_W-1:0] telem_val;
	logic scmd_stb;
	logic [sfp_frame_pkg::WORD_W-1:0] scmd;
	logic [sfp_frame_pkg::WORD_W-1:0] sdata;
	logic [sfp_frame_pkg::FRAME_W-1:0] peer_data;
	logic peer_valid;
	logic peer_ready;
	logic [sfp_frame_pkg::FRAME_W-1:0] local_data;
	logic local_valid;
	logic local_ready;
	logic [sfp_frame_pkg::FRAME_W-1:0] peer_pop_data;
	logic peer_pop_valid;
	logic peer_pop_ready;
	logic [CNT_W-1:0] peer_count;
	logic [sfp_frame_pkg::FRAME_W-1:0] local_pop_data;
	logic local_pop_valid;
	logic local_pop_ready;
	logic [CNT_W-1:0] local_count;

	sfp_host_regs u_regs (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
		.i_master(master), .i_channel_up(i_channel_up),
		.i_mrx_stb(mrx_stb), .i_mrx_data(mrx_data),
		.i_telem_stb(telem_stb), .i_telem_id(telem_id),
		.i_telem_idx(telem_idx), .i_telem_val(telem_val),
		.i_scmd_stb(scmd_stb), .i_scmd(scmd), .i_sdata(sdata),
		.o_en(en), .o_m_flag(m_flag), .o_m_cmd(m_cmd), .o_m_data(m_data),
		.o_s_flag(s_flag), .o_s_rsp(s_rsp)
	);

	sfp_handler #(
		.TELEM_PERIOD(TELEM_PERIOD),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_handler (
		.i_clk(i_clk), .i_rst(i_rst), .i_en(en),
		.i_node_id(i_node_id), .i_channel_up(i_channel_up),
		.i_m_flag(m_flag), .i_m_cmd(m_cmd), .i_m_data(m_data),
		.i_s_flag(s_flag), .i_s_rsp(s_rsp),
		.i_status(i_status), .i_intl(i_intl), .i_curr(i_curr), .i_volt(i_volt),
		.i_dc_curr(i_dc_curr), .i_dc_volt(i_dc_volt),
		.i_phase_r(i_phase_r), .i_phase_s(i_phase_s), .i_phase_t(i_phase_t),
		.o_tx_data(o_tx_data), .o_tx_valid(o_tx_valid), .i_tx_ready(i_tx_ready),
		.i_rx_data(i_rx_data), .i_rx_valid(i_rx_valid), .o_rx_ready(o_rx_ready),
		.o_peer_data(peer_data), .o_peer_valid(peer_valid), .i_peer_ready(peer_ready),
		.o_local_data(local_data), .o_local_valid(local_valid),
		.i_local_ready(local_ready),
		.i_peer_pop_data(peer_pop_data), .i_peer_pop_valid(peer_pop_valid),
		.o_peer_pop_ready(peer_pop_ready), .i_peer_count(peer_count),
		.i_local_pop_data(local_pop_data), .i_local_pop_valid(local_pop_valid),
		.o_local_pop_ready(local_pop_ready), .i_local_count(local_count),
		.o_master(master), .o_mrx_stb(mrx_stb), .o_mrx_data(mrx_data),
		.o_telem_stb(telem_stb), .o_telem_id(telem_id),
		.o_telem_idx(telem_idx), .o_telem_val(telem_val),
		.o_scmd_stb(scmd_stb), .o_scmd(scmd), .o_sdata(sdata)
	);

	// responses.
	sfp_frame_fifo #(.DEPTH(FIFO_DEPTH)) u_peer_fifo (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_push_data(peer_data), .i_push_valid(peer_valid), .o_push_ready(peer_ready),
		.o_pop_data(peer_pop_data), .o_pop_valid(peer_pop_valid),
		.i_pop_ready(peer_pop_ready), .o_count(peer_count)
	);

	// telemetry.
	sfp_frame_fifo #(.DEPTH(FIFO_DEPTH)) u_local_fifo (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_push_data(local_data), .i_push_valid(local_valid), .o_push_ready(local_ready),
		.o_pop_data(local_pop_data), .o_pop_valid(local_pop_valid),
		.i_pop_ready(local_pop_ready), .o_count(local_count)
	);

endmodule

// ==== verif/sfp_node_tb.sv ====
`timescale 1ns/1ps

module sfp_node_tb;

	localparam int TELEM_PERIOD = 200;
	localparam int FIFO_DEPTH = 16;

	logic i_clk;
	logic i_rst;
	logic [sfp_frame_pkg::ID_W-1:0] i_node_id;
	logic i_channel_up;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	logic [sfp_reg_pkg::ADDR_W-1:0] i_wb_adr;
	logic [31:0] i_wb_dat;
	logic [31:0] o_wb_dat;
	logic o_wb_ack;
	logic [63:0] o_tx_data;
	logic o_tx_valid;
	logic i_tx_ready;
	logic [63:0] i_rx_data;
	logic i_rx_valid;
	logic o_rx_ready;
	logic [31:0] meas [9];

	integer stim_seed = 26043;
	integer ready_seed = 26043;
	int errors = 0;
	int hold = 0;
	logic [63:0] tx_q [$]; // frames taken by the link partner.
	logic [63:0] tel_exp [$];
	logic [63:0] cmd_exp [$];
	logic [63:0] seen;

	sfp_node_top #(
		.TELEM_PERIOD(TELEM_PERIOD),
		.FIFO_DEPTH(FIFO_DEPTH)
	) UUT (
		.i_clk(i_clk), .i_rst(i_rst), .i_node_id(i_node_id), .i_channel_up(i_channel_up),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
		.o_tx_data(o_tx_data), .o_tx_valid(o_tx_valid), .i_tx_ready(i_tx_ready),
		.i_rx_data(i_rx_data), .i_rx_valid(i_rx_valid), .o_rx_ready(o_rx_ready),
		.i_status(meas[0]), .i_intl(meas[1]), .i_curr(meas[2]), .i_volt(meas[3]),
		.i_dc_curr(meas[4]), .i_dc_volt(meas[5]),
		.i_phase_r(meas[6]), .i_phase_s(meas[7]), .i_phase_t(meas[8])
	);

	always #5 i_clk = ~i_clk;

	function automatic logic [63:0] expect_frame(input logic telem, input logic [1:0] id,
		input logic [3:0] idx, input logic [31:0] hi, input logic [31:0] lo);
		if (telem)
			return {id, sfp_frame_pkg::TELEM_MARK, idx, lo};
		else
			return {hi, lo};
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic close_run();
		$display("run finished with %0d errors", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	endtask

	task automatic timed_out(input string what);
		errors++;
		$display("timeout while waiting for %s", what);
		close_run();
	endtask

	task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		@(negedge i_clk);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = we;
		i_wb_adr = adr;
		i_wb_dat = wdat;
		waited = 0;
		@(negedge i_clk);
		while (!o_wb_ack)
		begin
			if (waited == 8)
				timed_out("Wishbone ack");
			waited++;
			@(negedge i_clk);
		end
		rdat = o_wb_dat; // valid with ack.
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_access(1'b1, adr, dat, unused);
	endtask

	task automatic read_check(input string name, input logic [7:0] adr,
		input logic [31:0] exp);
		logic [31:0] got;
		bus_access(1'b0, adr, 32'h0, got);
		check_value(name, {32'h0, got}, {32'h0, exp});
	endtask

	task automatic inject_frame(input logic [63:0] frame);
		@(negedge i_clk);
		i_rx_data = frame;
		i_rx_valid = 1'b1;
		check_value("o_rx_ready", {63'h0, o_rx_ready}, 64'h1); // receive never stalls.
		@(negedge i_clk);
		i_rx_valid = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge i_clk);
	endtask

	task automatic apply_reset(input logic [1:0] id);
		@(negedge i_clk);
		i_rst = 1'b0;
		i_node_id = id;
		i_channel_up = 1'b0;
		tx_q.delete();
		tel_exp.delete();
		cmd_exp.delete();
		repeat (5) @(negedge i_clk);
		i_rst = 1'b1;
	endtask

	task automatic queue_telemetry(input logic [1:0] id);
		for (int k = 0; k < 9; k++)
			tel_exp.push_back(expect_frame(1'b1, id, 4'(k), 32'h0, meas[k]));
	endtask

	task automatic wait_drained(input int limit, input string what);
		int waited;
		waited = 0;
		while (tel_exp.size() != 0 || cmd_exp.size() != 0)
		begin
			if (waited == limit)
				timed_out(what);
			waited++;
			@(negedge i_clk);
		end
	endtask

	// link partner with random back-pressure.
	always @(negedge i_clk)
	begin
		if (!o_tx_valid)
		begin
			i_tx_ready = 1'b0;
			hold = $unsigned($random(ready_seed)) % 4; // stall drawn before each frame.
		end
		else if (hold > 0)
		begin
			hold--;
			i_tx_ready = 1'b0;
		end
		else
		begin
			i_tx_ready = 1'b1;
			tx_q.push_back(o_tx_data); // transfers on the next rising edge.
		end
	end

	always @(posedge i_clk)
	begin
		while (tx_q.size() > 0)
		begin
			seen = tx_q.pop_front();
			if (seen[61:36] == sfp_frame_pkg::TELEM_MARK && tel_exp.size() != 0)
				check_value("o_tx_data telemetry", seen, tel_exp.pop_front());
			else if (seen[61:36] != sfp_frame_pkg::TELEM_MARK && cmd_exp.size() != 0)
				check_value("o_tx_data", seen, cmd_exp.pop_front());
			else
			begin
				errors++;
				$display("unexpected frame on the link: 0x%h", seen);
			end
		end
	end

	initial
	begin
		logic [31:0] cmd;
		logic [31:0] data;
		logic [1:0] id;
		logic [3:0] idx;
		logic [7:0] adr;
		i_clk = 1'b0;
		i_rst = 1'b0;
		i_node_id = '0;
		i_channel_up = 1'b0;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		i_tx_ready = 1'b0;
		i_rx_data = '0;
		i_rx_valid = 1'b0;
		for (int k = 0; k < 9; k++)
			meas[k] = $random(stim_seed);

		apply_reset(2'd0);
		check_value("o_tx_valid", {63'h0, o_tx_valid}, 64'h0);
		for (int a = 0; a <= 9; a++)
			read_check($sformatf("register 0x%02h", 8'(a * 4)), 8'(a * 4), 32'h0);
		read_check("telemetry mirror", 8'h40, 32'h0);
		read_check("telemetry mirror", 8'hE0, 32'h0);

		write_reg(sfp_reg_pkg::REG_CTRL, 32'h1 << sfp_reg_pkg::CTRL_EN);
		read_check("REG_STATUS", sfp_reg_pkg::REG_STATUS, 32'h1 << sfp_reg_pkg::ST_MASTER);
		for (int n = 0; n < 2; n++)
		begin
			cmd = 32'hA5C3_0010 + n;
			data = $random(stim_seed);
			write_reg(sfp_reg_pkg::REG_CMD, cmd);
			write_reg(sfp_reg_pkg::REG_DATA, data);
			cmd_exp.push_back(expect_frame(1'b0, 2'd0, 4'd0, cmd, data));
			write_reg(sfp_reg_pkg::REG_CTRL, 32'h3);
			wait_drained(60, "master frame");
			idle_cycles(40); // a second send would show as unexpected.
			write_reg(sfp_reg_pkg::REG_CTRL, 32'h1);
		end

		for (int n = 0; n < 6; n++)
		begin
			id = 2'(1 + n % 3);
			idx = 4'($unsigned($random(stim_seed)) % 9);
			data = $random(stim_seed);
			inject_frame(expect_frame(1'b1, id, idx, 32'h0, data));
			adr = 8'(id) * sfp_reg_pkg::TELEM_BASE + 8'(idx) * 8'd4;
			read_check($sformatf("telemetry mirror 0x%02h", adr), adr, data);
		end
		data = $random(stim_seed);
		inject_frame(expect_frame(1'b0, 2'd0, 4'd0, 32'h1234_5678, data));
		read_check("REG_RX_HI", sfp_reg_pkg::REG_RX_HI, 32'h1234_5678);
		read_check("REG_RX_LO", sfp_reg_pkg::REG_RX_LO, data);

		apply_reset(2'd2);
		write_reg(sfp_reg_pkg::REG_CTRL, 32'h1);
		cmd = 32'h5A00_0042;
		data = $random(stim_seed);
		inject_frame({cmd, data});
		read_check("REG_STATUS", sfp_reg_pkg::REG_STATUS, 32'h1 << sfp_reg_pkg::ST_PEND);
		read_check("REG_SCMD", sfp_reg_pkg::REG_SCMD, cmd);
		read_check("REG_SDATA", sfp_reg_pkg::REG_SDATA, data);
		read_check("REG_STATUS", sfp_reg_pkg::REG_STATUS, 32'h0);

		queue_telemetry(2'd2);
		@(negedge i_clk);
		i_channel_up = 1'b1;
		wait_drained(400, "first telemetry period");
		queue_telemetry(2'd2);
		wait_drained(300, "second telemetry period");
		i_channel_up = 1'b0;
		idle_cycles(450); // channel down, nothing may be sent.

		queue_telemetry(2'd2);
		queue_telemetry(2'd2);
		cmd = 32'hC0DE_0001;
		data = $random(stim_seed);
		write_reg(sfp_reg_pkg::REG_RSP_HI, cmd);
		write_reg(sfp_reg_pkg::REG_RSP_LO, data);
		cmd_exp.push_back(expect_frame(1'b0, 2'd2, 4'd0, cmd, data));
		i_channel_up = 1'b1;
		write_reg(sfp_reg_pkg::REG_CTRL, 32'h5);
		wait_drained(700, "response and telemetry");
		i_channel_up = 1'b0;
		write_reg(sfp_reg_pkg::REG_CTRL, 32'h1);
		idle_cycles(300);
		close_run();
	end

endmodule

// ==== list.f ====
logic/sfp_frame_pkg.sv
logic/sfp_reg_pkg.sv
logic/sfp_frame_fifo.sv
logic/sfp_handler.sv
logic/sfp_host_regs.sv
logic/sfp_node_top.sv
verif/sfp_node_tb.sv

// ==== Makefile ====
TOP = sfp_node_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o V$(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module sfp_node_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
